/* tb.f */
+incdir+design
design/lsu_pkg.sv
design/lsu_align.sv
design/lsu.sv
design/axi_sram.sv
design/lsu_top.sv
test/lsu_tb.sv

/* Makefile */
# Verilator flow for the load/store unit and its SRAM slave.

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module lsu_top

sim:
	verilator --binary --timing --assert -f tb.f --top-module lsu_tb -Mdir obj_dir -o lsu_tb
	./obj_dir/lsu_tb

clean:
	rm -rf obj_dir

/* test/lsu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_consts.svh"

module lsu_tb;
  import lsu_pkg::*;

  localparam int BYTE_IDX_W = $clog2(`MEM_WORDS * 4);
  localparam axsize_t SZ_BYTE = 3'd0;
  localparam axsize_t SZ_HALF = 3'd1;
  localparam axsize_t SZ_WORD = 3'd2;

  logic  clock;
  logic  arst_n;
  logic  ren;
  logic  wen;
  logic  is_byte;
  logic  is_half;
  logic  sext;
  addr_t addr;
  word_t wsrc;
  addr_t exu_pc;
  word_t exu_result;
  logic  kill;
  logic  busy;
  addr_t lsu_pc;
  word_t result;
  logic  bus_err;

  // byte-wide model of the sram contents.
  logic [7:0] ref_mem [`MEM_WORDS * 4];
  integer     seed;

  lsu_top dut0 (
    .clock      (clock),
    .arst_n     (arst_n),
    .ren        (ren),
    .wen        (wen),
    .is_byte    (is_byte),
    .is_half    (is_half),
    .sext       (sext),
    .addr       (addr),
    .wsrc       (wsrc),
    .exu_pc     (exu_pc),
    .exu_result (exu_result),
    .kill       (kill),
    .busy       (busy),
    .lsu_pc     (lsu_pc),
    .result     (result),
    .bus_err    (bus_err)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // each access needs latency plus three cycles.
  initial begin
    #(400 * (`MEM_LATENCY + 3) * 100);
    report_failure("watchdog timeout, the tests did not finish in time");
  end

  task automatic report_failure(input string msg);
    $display("STATUS: FAIL");
    $fatal(1, "%s", msg);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      report_failure("data word mismatch");
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      report_failure("address mismatch");
    end
  endtask

  task automatic check_resp(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      report_failure("status bit mismatch");
    end
  endtask

  function automatic logic [BYTE_IDX_W-1:0] byte_idx(input addr_t a);
    return a[BYTE_IDX_W-1:0];
  endfunction

  function automatic int lane_count(input axsize_t sz);
    return (sz == SZ_BYTE) ? 1 : ((sz == SZ_HALF) ? 2 : 4);
  endfunction

  // low bytes of the store data land at the addressed lanes.
  task automatic mem_model_write(input addr_t a, input word_t d, input axsize_t sz);
    int n;
    n = lane_count(sz);
    if (a < addr_t'(`MEM_WORDS * 4)) begin
      for (int i = 0; i < n; i++) begin
        ref_mem[byte_idx(a + addr_t'(i))] = d[8*i +: 8];
      end
    end
  endtask

  function automatic word_t expected_load(input addr_t a, input axsize_t sz, input logic sx);
    word_t raw;
    int    n;
    raw = '0;
    n = lane_count(sz);
    if (a < addr_t'(`MEM_WORDS * 4)) begin
      for (int i = 0; i < n; i++) begin
        raw[8*i +: 8] = ref_mem[byte_idx(a + addr_t'(i))];
      end
    end
    if (sx && n == 1) begin
      raw = {{24{raw[7]}}, raw[7:0]};
    end else if (sx && n == 2) begin
      raw = {{16{raw[15]}}, raw[15:0]};
    end
    return raw;
  endfunction

  task automatic step();
    @(posedge clock);
    #5;
  endtask

  task automatic wait_not_busy();
    while (busy) begin
      step();
    end
  endtask

  // one-cycle request that returns just after the request edge.
  task automatic issue(input logic rd, input addr_t a, input word_t d, input axsize_t sz,
                       input logic sx);
    ren     = rd;
    wen     = !rd;
    addr    = a;
    wsrc    = d;
    is_byte = (sz == SZ_BYTE);
    is_half = (sz == SZ_HALF);
    sext    = sx;
    step();
    ren = 1'b0;
    wen = 1'b0;
    if (!busy) begin
      report_failure("busy did not rise after a request");
    end
  endtask

  task automatic do_store(input addr_t a, input word_t d, input axsize_t sz);
    issue(1'b0, a, d, sz, 1'b0);
    wait_not_busy();
    mem_model_write(a, d, sz);
  endtask

  // result is only valid until the next idle edge.
  task automatic do_load(input addr_t a, input axsize_t sz, input logic sx,
                         output word_t data, output logic err);
    issue(1'b1, a, '0, sz, sx);
    wait_not_busy();
    data = result;
    err  = bus_err;
  endtask

  task automatic load_check(input addr_t a, input axsize_t sz, input logic sx);
    word_t data;
    logic  err;
    do_load(a, sz, sx, data, err);
    check_word("result", data, expected_load(a, sz, sx));
    check_resp("bus_err", err, 1'b0);
  endtask

  task automatic round_trip_words();
    addr_t addrs [6];
    word_t data;
    addrs = '{32'h0, 32'h4, 32'h10, 32'h80, 32'h200, 32'h3fc};
    foreach (addrs[i]) begin
      data = $random(seed);
      do_store(addrs[i], data, SZ_WORD);
      check_resp("bus_err", bus_err, 1'b0);
    end
    foreach (addrs[i]) begin
      load_check(addrs[i], SZ_WORD, 1'b0);
    end
  endtask

  task automatic merge_sub_word_stores();
    word_t data;
    data = $random(seed);
    do_store(32'h40, data, SZ_WORD);
    for (int i = 0; i < 4; i++) begin
      data = $random(seed);
      do_store(32'h40 + addr_t'(i), data, SZ_BYTE);
      check_resp("bus_err", bus_err, 1'b0);
      load_check(32'h40, SZ_WORD, 1'b0);
    end
    data = $random(seed);
    do_store(32'h44, data, SZ_WORD);
    for (int i = 0; i < 4; i += 2) begin
      data = $random(seed);
      do_store(32'h44 + addr_t'(i), data, SZ_HALF);
      load_check(32'h44, SZ_WORD, 1'b0);
    end
  endtask

  task automatic extend_loads();
    word_t data;
    // every byte lane gets its top bit set.
    data = $random(seed);
    do_store(32'h60, data | 32'h8080_8080, SZ_WORD);
    for (int i = 0; i < 4; i++) begin
      load_check(32'h60 + addr_t'(i), SZ_BYTE, 1'b1);
      load_check(32'h60 + addr_t'(i), SZ_BYTE, 1'b0);
    end
    for (int i = 0; i < 4; i += 2) begin
      load_check(32'h60 + addr_t'(i), SZ_HALF, 1'b1);
      load_check(32'h60 + addr_t'(i), SZ_HALF, 1'b0);
    end
  endtask

  task automatic access_out_of_range();
    addr_t oor;
    word_t data;
    logic  err;
    // aliases word 4 if the upper address bits were dropped.
    oor  = addr_t'(`MEM_WORDS * 4) + 32'h10;
    data = $random(seed);
    do_store(32'h10, data, SZ_WORD);
    do_load(oor, SZ_WORD, 1'b0, data, err);
    check_word("result", data, 32'h0);
    check_resp("bus_err", err, 1'b1);
    data = $random(seed);
    do_store(oor, data, SZ_WORD);
    check_resp("bus_err", bus_err, 1'b1);
    load_check(32'h10, SZ_WORD, 1'b0);
  endtask

  task automatic kill_and_pass_through();
    addr_t pc;
    addr_t oor;
    word_t res;
    pc         = $random(seed);
    res        = $random(seed);
    exu_pc     = pc;
    exu_result = res;
    step();
    check_addr("lsu_pc", lsu_pc, pc);
    check_word("result", result, res);
    exu_pc     = ~pc;
    exu_result = ~res;
    step();
    check_addr("lsu_pc", lsu_pc, ~pc);
    check_word("result", result, ~res);
    // request with kill high is dropped.
    ren  = 1'b1;
    addr = 32'h10;
    kill = 1'b1;
    step();
    ren  = 1'b0;
    kill = 1'b0;
    if (busy) begin
      report_failure("a request was taken while kill was high");
    end
    // out-of-range target whose response differs from the held values.
    oor        = addr_t'(`MEM_WORDS * 4) + 32'h20;
    res        = $random(seed);
    exu_result = res;
    issue(1'b1, oor, '0, SZ_WORD, 1'b0);
    kill       = 1'b1;
    exu_result = ~res;
    step();
    kill = 1'b0;
    wait_not_busy();
    check_word("result", result, res);
    check_resp("bus_err", bus_err, 1'b0);
    load_check(32'h10, SZ_WORD, 1'b0);
    do_store(32'h14, res, SZ_WORD);
    load_check(32'h14, SZ_WORD, 1'b0);
  endtask

  initial begin
    seed       = 67623;
    arst_n     = 1'b0;
    ren        = 1'b0;
    wen        = 1'b0;
    is_byte    = 1'b0;
    is_half    = 1'b0;
    sext       = 1'b0;
    kill       = 1'b0;
    addr       = '0;
    wsrc       = '0;
    exu_pc     = '0;
    exu_result = '0;
    repeat (8) @(posedge clock);
    #5;
    check_resp("busy", busy, 1'b0);
    check_resp("bus_err", bus_err, 1'b0);
    check_word("result", result, 32'h0);
    check_addr("lsu_pc", lsu_pc, 32'h0);
    arst_n = 1'b1;
    step();
    round_trip_words();
    merge_sub_word_stores();
    extend_loads();
    access_out_of_range();
    kill_and_pass_through();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* design/lsu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_top (
  input  logic           clock,
  input  logic           arst_n,
  input  logic           ren,
  input  logic           wen,
  input  logic           is_byte,
  input  logic           is_half,
  input  logic           sext,
  input  lsu_pkg::addr_t addr,
  input  lsu_pkg::word_t wsrc,
  input  lsu_pkg::addr_t exu_pc,
  input  lsu_pkg::word_t exu_result,
  input  logic           kill,
  output logic           busy,
  output lsu_pkg::addr_t lsu_pc,
  output lsu_pkg::word_t result,
  output logic           bus_err
);
  import lsu_pkg::*;

  // axi-lite wires between master and slave.
  logic    arvalid;
  logic    arready;
  addr_t   araddr;
  axsize_t arsize;
  logic    rvalid;
  logic    rready;
  word_t   rdata;
  resp_t   rresp;
  logic    awvalid;
  logic    awready;
  addr_t   awaddr;
  axsize_t awsize;
  logic    wvalid;
  logic    wready;
  word_t   wdata;
  strb_t   wstrb;
  logic    bvalid;
  logic    bready;
  resp_t   bresp;

  lsu u_lsu (
    .clock      (clock),
    .arst_n     (arst_n),
    .ren        (ren),
    .wen        (wen),
    .is_byte    (is_byte),
    .is_half    (is_half),
    .sext       (sext),
    .kill       (kill),
    .addr       (addr),
    .wsrc       (wsrc),
    .exu_pc     (exu_pc),
    .exu_result (exu_result),
    .busy       (busy),
    .lsu_pc     (lsu_pc),
    .result     (result),
    .bus_err    (bus_err),
    .arvalid    (arvalid),
    .arready    (arready),
    .araddr     (araddr),
    .arsize     (arsize),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .rresp      (rresp),
    .awvalid    (awvalid),
    .awready    (awready),
    .awaddr     (awaddr),
    .awsize     (awsize),
    .wvalid     (wvalid),
    .wready     (wready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .bvalid     (bvalid),
    .bready     (bready),
    .bresp      (bresp)
  );

  axi_sram u_sram (
    .clock   (clock),
    .arst_n  (arst_n),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .arsize  (arsize),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .awsize  (awsize),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp)
  );

endmodule

`default_nettype wire

/* design/axi_sram.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_consts.svh"

module axi_sram (
  input  logic             clock,
  input  logic             arst_n,
  input  logic             arvalid,
  output logic             arready,
  input  lsu_pkg::addr_t   araddr,
  input  lsu_pkg::axsize_t arsize,
  output logic             rvalid,
  input  logic             rready,
  output lsu_pkg::word_t   rdata,
  output lsu_pkg::resp_t   rresp,
  input  logic             awvalid,
  output logic             awready,
  input  lsu_pkg::addr_t   awaddr,
  input  lsu_pkg::axsize_t awsize,
  input  logic             wvalid,
  output logic             wready,
  input  lsu_pkg::word_t   wdata,
  input  lsu_pkg::strb_t   wstrb,
  output logic             bvalid,
  input  logic             bready,
  output lsu_pkg::resp_t   bresp
);
  import lsu_pkg::*;

  localparam int IDX_W = $clog2(`MEM_WORDS);
  localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

  word_t            mem [`MEM_WORDS];
  logic             pending;
  logic             pend_wr;
  logic [CNT_W-1:0] cnt;
  logic             ar_hs;
  logic             wr_hs;
  logic             ar_ok;
  logic             aw_ok;
  logic [IDX_W-1:0] ar_idx;
  logic [IDX_W-1:0] aw_idx;
  strb_t            rd_mask;
  strb_t            wr_mask;

  // lanes covered by an access of this size.
  function automatic strb_t size_mask(axsize_t size, logic [1:0] offset);
    strb_t m;
    case (size)
      3'd0: m = 4'b0001;
      3'd1: m = 4'b0011;
      default: m = 4'b1111;
    endcase
    return m << offset;
  endfunction

  assign ar_hs   = arvalid && arready;
  assign wr_hs   = awvalid && awready && wvalid && wready;
  assign ar_ok   = araddr < addr_t'(`MEM_WORDS * 4);
  assign aw_ok   = awaddr < addr_t'(`MEM_WORDS * 4);
  assign ar_idx  = araddr[IDX_W+1:2];
  assign aw_idx  = awaddr[IDX_W+1:2];
  assign rd_mask = size_mask(arsize, araddr[1:0]);
  assign wr_mask = wstrb & size_mask(awsize, awaddr[1:0]);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      arready <= 1'b0;
      awready <= 1'b0;
      wready  <= 1'b0;
      rvalid  <= 1'b0;
      bvalid  <= 1'b0;
      pending <= 1'b0;
      pend_wr <= 1'b0;
      cnt     <= '0;
    end else begin
      // one-cycle ready pulse when idle, reads first.
      if (!pending && !arready && !awready) begin
        if (arvalid) begin
          arready <= 1'b1;
        end else if (awvalid && wvalid) begin
          awready <= 1'b1;
          wready  <= 1'b1;
        end
      end else begin
        arready <= 1'b0;
        awready <= 1'b0;
        wready  <= 1'b0;
      end
      if (ar_hs || wr_hs) begin
        pending <= 1'b1;
        pend_wr <= wr_hs;
        cnt     <= CNT_W'(`MEM_LATENCY);
      end else if (pending && cnt != '0) begin
        cnt <= cnt - 1'b1;
        if (cnt == CNT_W'(1)) begin
          if (pend_wr) begin
            bvalid <= 1'b1;
          end else begin
            rvalid <= 1'b1;
          end
        end
      end
      if (rvalid && rready) begin
        rvalid  <= 1'b0;
        pending <= 1'b0;
      end
      if (bvalid && bready) begin
        bvalid  <= 1'b0;
        pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (ar_hs) begin
      for (int i = 0; i < 4; i++) begin
        rdata[8*i +: 8] <= (ar_ok && rd_mask[i]) ? mem[ar_idx][8*i +: 8] : 8'h00;
      end
      rresp <= ar_ok ? `RESP_OKAY : `RESP_SLVERR;
    end
    if (wr_hs) begin
      if (aw_ok) begin
        for (int i = 0; i < 4; i++) begin
          if (wr_mask[i]) begin
            mem[aw_idx][8*i +: 8] <= wdata[8*i +: 8];
          end
        end
      end
      bresp <= aw_ok ? `RESP_OKAY : `RESP_SLVERR;
    end
  end

  r_hold: assert property (@(posedge clock) disable iff (!arst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

  b_hold: assert property (@(posedge clock) disable iff (!arst_n)
    bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

`default_nettype wire

/* design/lsu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_consts.svh"

module lsu (
  input  logic             clock,
  input  logic             arst_n,
  input  logic             ren,
  input  logic             wen,
  input  logic             is_byte,
  input  logic             is_half,
  input  logic             sext,
  input  logic             kill,
  input  lsu_pkg::addr_t   addr,
  input  lsu_pkg::word_t   wsrc,
  input  lsu_pkg::addr_t   exu_pc,
  input  lsu_pkg::word_t   exu_result,
  output logic             busy,
  output lsu_pkg::addr_t   lsu_pc,
  output lsu_pkg::word_t   result,
  output logic             bus_err,
  output logic             arvalid,
  input  logic             arready,
  output lsu_pkg::addr_t   araddr,
  output lsu_pkg::axsize_t arsize,
  input  logic             rvalid,
  output logic             rready,
  input  lsu_pkg::word_t   rdata,
  input  lsu_pkg::resp_t   rresp,
  output logic             awvalid,
  input  logic             awready,
  output lsu_pkg::addr_t   awaddr,
  output lsu_pkg::axsize_t awsize,
  output logic             wvalid,
  input  logic             wready,
  output lsu_pkg::word_t   wdata,
  output lsu_pkg::strb_t   wstrb,
  input  logic             bvalid,
  output logic             bready,
  input  lsu_pkg::resp_t   bresp
);
  import lsu_pkg::*;

  lsu_state_e state;
  addr_t      addr_q;
  axsize_t    size_q;
  axsize_t    req_size;
  logic       sext_q;
  word_t      wsrc_q;
  word_t      load_result;
  logic       req_take;
  logic       ar_hs;
  logic       r_hs;
  logic       aw_hs;
  logic       w_hs;
  logic       b_hs;
  logic       write_done;

  assign req_take   = (state == idle) && (ren || wen) && !kill;
  assign req_size   = is_byte ? axsize_t'(0) : (is_half ? axsize_t'(1) : axsize_t'(2));
  assign ar_hs      = arvalid && arready;
  assign r_hs       = rvalid && rready;
  assign aw_hs      = awvalid && awready;
  assign w_hs       = wvalid && wready;
  assign b_hs       = bvalid && bready;
  assign write_done = (!awvalid || awready) && (!wvalid || wready);

  assign araddr = addr_q;
  assign arsize = size_q;
  assign awaddr = addr_q;
  assign awsize = size_q;

  lsu_align u_align (
    .size        (size_q),
    .offset      (addr_q[1:0]),
    .sext        (sext_q),
    .store_data  (wsrc_q),
    .load_data   (rdata),
    .wdata       (wdata),
    .wstrb       (wstrb),
    .load_result (load_result)
  );

  always_ff @(posedge clock) begin
    if (req_take) begin
      addr_q <= addr;
      size_q <= req_size;
      sext_q <= sext;
      wsrc_q <= wsrc;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state   <= idle;
      busy    <= 1'b0;
      lsu_pc  <= '0;
      result  <= '0;
      bus_err <= 1'b0;
      arvalid <= 1'b0;
      rready  <= 1'b0;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b0;
    end else if (state == idle) begin
      lsu_pc <= exu_pc;
      result <= exu_result;
      if (req_take) begin
        busy <= 1'b1;
        if (ren) begin
          arvalid <= 1'b1;
          state   <= read_addr;
        end else begin
          awvalid <= 1'b1;
          wvalid  <= 1'b1;
          state   <= write;
        end
      end
    end else begin
      // channel bookkeeping shared with drain.
      if (ar_hs) begin
        arvalid <= 1'b0;
        rready  <= 1'b1;
      end
      if (aw_hs) begin
        awvalid <= 1'b0;
      end
      if (w_hs) begin
        wvalid <= 1'b0;
        bready <= 1'b1;
      end
      if (r_hs) begin
        rready <= 1'b0;
      end
      if (b_hs) begin
        bready <= 1'b0;
      end
      if (r_hs || b_hs) begin
        busy  <= 1'b0;
        state <= idle;
      end
      case (state)
        read_addr: if (ar_hs) state <= read_data;
        read_data: begin
          if (r_hs && !kill) begin
            result  <= load_result;
            bus_err <= (rresp == `RESP_SLVERR);
          end
        end
        write: if (write_done) state <= write_resp;
        write_resp: begin
          if (b_hs && !kill) begin
            bus_err <= (bresp == `RESP_SLVERR);
          end
        end
        default: ;
      endcase
      // killed access finishes its bus traffic silently.
      if (kill && !(r_hs || b_hs)) begin
        state <= drain;
      end
    end
  end

  ar_hold: assert property (@(posedge clock) disable iff (!arst_n)
    arvalid && !arready |=> arvalid && $stable(araddr));

  aw_hold: assert property (@(posedge clock) disable iff (!arst_n)
    awvalid && !awready |=> awvalid && $stable(awaddr));

  aw_with_w: assert property (@(posedge clock) disable iff (!arst_n)
    $rose(awvalid) |-> $rose(wvalid));

  // idle means no access and no open channel.
  idle_quiet: assert property (@(posedge clock) disable iff (!arst_n)
    state == idle |-> !busy && !arvalid && !awvalid && !wvalid && !rready && !bready);

endmodule

`default_nettype wire

/* design/lsu_align.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_align (
  input  lsu_pkg::axsize_t size,
  input  logic [1:0]       offset,
  input  logic             sext,
  input  lsu_pkg::word_t   store_data,
  input  lsu_pkg::word_t   load_data,
  output lsu_pkg::word_t   wdata,
  output lsu_pkg::strb_t   wstrb,
  output lsu_pkg::word_t   load_result
);
  import lsu_pkg::*;

  logic [4:0] shamt;
  word_t      lane_data;

  assign shamt = {offset, 3'b000};

  // read data moved down to bit 0.
  assign lane_data = load_data >> shamt;

  always_comb begin
    case (size)
      3'd0: begin
        wdata = store_data << shamt;
        wstrb = strb_t'(4'b0001 << offset);
        if (sext) begin
          load_result = {{24{lane_data[7]}}, lane_data[7:0]};
        end else begin
          load_result = {24'b0, lane_data[7:0]};
        end
      end
      3'd1: begin
        wdata = store_data << shamt;
        wstrb = strb_t'(4'b0011 << offset);
        if (sext) begin
          load_result = {{16{lane_data[15]}}, lane_data[15:0]};
        end else begin
          load_result = {16'b0, lane_data[15:0]};
        end
      end
      default: begin
        // full word, no lane shift.
        wdata       = store_data;
        wstrb       = 4'b1111;
        load_result = load_data;
      end
    endcase
  end

endmodule

`default_nettype wire

/* design/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0] strb_t;

  // 0 byte, 1 half, 2 word.
  typedef logic [2:0] axsize_t;
  typedef logic [1:0] resp_t;

  typedef enum logic [2:0] {
    idle,
    read_addr,
    read_data,
    write,
    write_resp,
    drain
  } lsu_state_e;

endpackage

`default_nettype wire

/* design/lsu_consts.svh */
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// sram depth in 32-bit words.
`define MEM_WORDS 256

// cycles from address acceptance to response valid.
`define MEM_LATENCY 2

// axi response codes.
`define RESP_OKAY 2'b00
`define RESP_SLVERR 2'b10

`endif
